//--- Makefile
# Verilator build and run for the Pep/9 core testbench

VERILATOR ?= verilator
TOP       ?= pep9CoreTb
FILELIST  ?= pep9Core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
	    echo "Test run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- pep9Core.f
src/pep9Pkg.sv
src/pep9Ifs.sv
src/instrDecoder.sv
src/addLogicUnit.sv
src/shiftUnit.sv
src/resultMerge.sv
src/regFile.sv
src/pep9Core.sv
tests/pep9Core_assert.sv
tests/pep9CoreChecker.sv
tests/pep9CoreTb.sv

//--- src/addLogicUnit.sv
// Adder and logic unit
module addLogicUnit
(
    input  logic        Sysclk,
    input  logic        arstN,
    execIf.sink         exec,
    unitResultIf.source res
);

    logic                           isSub;
    logic                           hit;
    pep9Pkg::byteT                  bEff;
    logic [pep9Pkg::dataWidth:0]    sum;   // Carry out on top
    pep9Pkg::byteT                  nextValue;
    logic                           nextOverflow;
    pep9Pkg::statusT                nextMask;

    assign hit   = exec.valid && exec.unitSel == pep9Pkg::unitAddLogic;
    assign isSub = exec.aluOp == pep9Pkg::opSub;
    assign bEff  = isSub ? ~exec.opndB : exec.opndB;     // A + ~B + 1
    assign sum   = {1'b0, exec.opndA} + {1'b0, bEff} + {{pep9Pkg::dataWidth{1'b0}}, isSub};

    always_comb
    begin
        nextValue    = sum[pep9Pkg::dataWidth-1:0];
        nextOverflow = (exec.opndA[7] == bEff[7]) && (sum[7] != exec.opndA[7]);
        nextMask     = '{n: 1'b1, z: 1'b1, v: 1'b1, c: 1'b1};
        case (exec.aluOp)
            pep9Pkg::opAnd:  nextValue = exec.opndA & exec.opndB;
            pep9Pkg::opOr:   nextValue = exec.opndA | exec.opndB;
            pep9Pkg::opLoad: nextValue = exec.opndB;
            default:         nextValue = sum[pep9Pkg::dataWidth-1:0];
        endcase
        if (exec.aluOp != pep9Pkg::opAdd && !isSub)
            nextMask = '{n: 1'b1, z: 1'b1, v: 1'b0, c: 1'b0};  // Logic ops touch N and Z
    end

    always_ff @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
            res.valid <= 1'b0;
        else
            res.valid <= hit;
    end

    always_ff @(posedge Sysclk)
    begin
        if (hit)
        begin
            res.value    <= nextValue;
            res.carry    <= sum[pep9Pkg::dataWidth];
            res.overflow <= nextOverflow;
            res.flagMask <= nextMask;
            res.dest     <= exec.dest;
            res.writeEn  <= exec.writeEn;
        end
    end

endmodule

//--- src/instrDecoder.sv
// Instruction accept and decode
module instrDecoder
(
    input  logic            Sysclk,
    input  logic            arstN,
    input  logic            instrValid,
    input  pep9Pkg::byteT   instrSpec,
    input  pep9Pkg::byteT   operand,
    input  pep9Pkg::byteT   regA,
    input  pep9Pkg::byteT   regX,
    input  pep9Pkg::statusT status,
    input  logic            done,
    output logic            instrReady,
    execIf.source           exec
);

    logic               busy;
    logic               accept;
    pep9Pkg::byteT      unaryOff;
    pep9Pkg::unitSelT   decUnit;
    pep9Pkg::aluOpT     decOp;
    pep9Pkg::regSelT    decDest;
    logic               decWrite;

    assign instrReady = !busy || done;   // Free again in the completion cycle
    assign accept     = instrValid && instrReady;
    assign unaryOff   = instrSpec - pep9Pkg::specUnaryFirst;

    always_comb
    begin
        decUnit  = pep9Pkg::unitNone;
        decOp    = pep9Pkg::opNone;
        decDest  = pep9Pkg::regSelA;
        decWrite = 1'b0;
        if (instrSpec >= pep9Pkg::specUnaryFirst && instrSpec <= pep9Pkg::specUnaryLast)
        begin
            decUnit  = pep9Pkg::unitShift;
            decDest  = pep9Pkg::regSelT'(instrSpec[0]);
            decWrite = 1'b1;
            case (unaryOff[3:1])                 // Pairs of A and X specifiers
                3'd0:    decOp = pep9Pkg::opNot;
                3'd1:    decOp = pep9Pkg::opNeg;
                3'd2:    decOp = pep9Pkg::opAsl;
                3'd3:    decOp = pep9Pkg::opAsr;
                3'd4:    decOp = pep9Pkg::opRol;
                3'd5:    decOp = pep9Pkg::opRor;
                default: decOp = pep9Pkg::opNone;
            endcase
        end
        else if (instrSpec[2:0] == pep9Pkg::addrImmediate)
        begin
            decUnit  = pep9Pkg::unitAddLogic;
            decDest  = pep9Pkg::regSelT'(instrSpec[3]);
            decWrite = 1'b1;
            case (instrSpec[7:4])
                pep9Pkg::specAdd: decOp = pep9Pkg::opAdd;
                pep9Pkg::specSub: decOp = pep9Pkg::opSub;
                pep9Pkg::specAnd: decOp = pep9Pkg::opAnd;
                pep9Pkg::specOr:  decOp = pep9Pkg::opOr;
                pep9Pkg::specLd:  decOp = pep9Pkg::opLoad;
                pep9Pkg::specCp:
                begin
                    decOp    = pep9Pkg::opSub;  // Flags only
                    decWrite = 1'b0;
                end
                default:
                begin
                    decUnit  = pep9Pkg::unitNone;
                    decWrite = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
        begin
            busy       <= 1'b0;
            exec.valid <= 1'b0;
        end
        else
        begin
            exec.valid <= accept;
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    // Operand capture
    always_ff @(posedge Sysclk)
    begin
        if (accept)
        begin
            exec.unitSel <= decUnit;
            exec.aluOp   <= decOp;
            exec.dest    <= decDest;
            exec.writeEn <= decWrite;
            exec.opndA   <= (decDest == pep9Pkg::regSelX) ? regX : regA;
            exec.opndB   <= operand;
            exec.carryIn <= status.c;
        end
    end

endmodule

//--- src/pep9Core.sv
// Pep/9 execution core top
module pep9Core
(
    input  logic            Sysclk,
    input  logic            arstN,
    input  logic            instrValid,
    input  pep9Pkg::byteT   instrSpec,
    input  pep9Pkg::byteT   operand,
    output logic            instrReady,
    output logic            resultValid,
    output logic            illegalOp,
    output pep9Pkg::byteT   regA,
    output pep9Pkg::byteT   regX,
    output pep9Pkg::statusT status
);

    logic               wrEn;
    pep9Pkg::regSelT    wrSel;
    pep9Pkg::byteT      wrData;
    pep9Pkg::statusT    statusNext;

    execIf       execBus ();
    unitResultIf addRes ();
    unitResultIf shiftRes ();

    instrDecoder decoder_inst
    (
        .Sysclk     (Sysclk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrSpec  (instrSpec),
        .operand    (operand),
        .regA       (regA),
        .regX       (regX),
        .status     (status),
        .done       (resultValid),   // Completion frees the decoder
        .instrReady (instrReady),
        .exec       (execBus.source)
    );

    // Both units see every pulse and pick out their own operations
    addLogicUnit addLogic_inst
    (
        .Sysclk (Sysclk),
        .arstN  (arstN),
        .exec   (execBus.sink),
        .res    (addRes.source)
    );

    shiftUnit shift_inst
    (
        .Sysclk (Sysclk),
        .arstN  (arstN),
        .exec   (execBus.sink),
        .res    (shiftRes.source)
    );

    resultMerge merge_inst
    (
        .Sysclk      (Sysclk),
        .arstN       (arstN),
        .exec        (execBus.sink),
        .addRes      (addRes.sink),
        .shiftRes    (shiftRes.sink),
        .status      (status),
        .wrEn        (wrEn),
        .wrSel       (wrSel),
        .wrData      (wrData),
        .statusNext  (statusNext),
        .resultValid (resultValid),
        .illegalOp   (illegalOp)
    );

    regFile regs_inst
    (
        .Sysclk     (Sysclk),
        .arstN      (arstN),
        .wrEn       (wrEn),
        .wrSel      (wrSel),
        .wrData     (wrData),
        .statusNext (statusNext),
        .regA       (regA),
        .regX       (regX),
        .status     (status)
    );

endmodule

//--- src/pep9Ifs.sv
// Pep/9 core internal buses

// Decoded instruction with a one-cycle valid pulse
interface execIf;
    logic               valid;
    pep9Pkg::unitSelT   unitSel;
    pep9Pkg::aluOpT     aluOp;
    pep9Pkg::byteT      opndA;    // Selected register
    pep9Pkg::byteT      opndB;    // Immediate
    logic               carryIn;  // Stored C bit
    pep9Pkg::regSelT    dest;
    logic               writeEn;  // Low for CPWr and illegal specifiers

    modport source (output valid, unitSel, aluOp, opndA, opndB, carryIn, dest, writeEn);
    modport sink   (input  valid, unitSel, aluOp, opndA, opndB, carryIn, dest, writeEn);
endinterface

// Registered result of one execution unit
interface unitResultIf;
    logic               valid;
    pep9Pkg::byteT      value;
    logic               carry;
    logic               overflow;
    pep9Pkg::statusT    flagMask; // Status bits this operation updates
    pep9Pkg::regSelT    dest;
    logic               writeEn;

    modport source (output valid, value, carry, overflow, flagMask, dest, writeEn);
    modport sink   (input  valid, value, carry, overflow, flagMask, dest, writeEn);
endinterface

//--- src/pep9Pkg.sv
// Pep/9 core shared definitions
package pep9Pkg;

    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] byteT;

    // Bit 0 (unary) or bit 3 (non-unary) of the specifier
    typedef enum logic
    {
        regSelA = 1'b0,
        regSelX = 1'b1
    } regSelT;

    typedef enum logic [3:0]
    {
        opAdd,
        opSub,     // Also CPWr
        opAnd,
        opOr,
        opLoad,
        opNot,
        opNeg,
        opAsl,
        opAsr,
        opRol,
        opRor,
        opNone
    } aluOpT;

    typedef enum logic [1:0]
    {
        unitAddLogic,
        unitShift,
        unitNone
    } unitSelT;

    typedef struct packed
    {
        logic n;
        logic z;
        logic v;
        logic c;
    } statusT;

    // NOTA at the bottom, RORX at the top
    localparam byteT specUnaryFirst = 8'h18;
    localparam byteT specUnaryLast  = 8'h23;

    // Opcode groups in specifier bits 7..4
    localparam logic [3:0] specAdd = 4'd6;
    localparam logic [3:0] specSub = 4'd7;
    localparam logic [3:0] specAnd = 4'd8;
    localparam logic [3:0] specOr  = 4'd9;
    localparam logic [3:0] specCp  = 4'd10;
    localparam logic [3:0] specLd  = 4'd12;

    localparam logic [2:0] addrImmediate = 3'b000;

    // Edges from acceptance to resultValid
    localparam int coreLatency = 3;

endpackage

//--- src/regFile.sv
// A and X low bytes with NZVC
module regFile
(
    input  logic            Sysclk,
    input  logic            arstN,
    input  logic            wrEn,
    input  pep9Pkg::regSelT wrSel,
    input  pep9Pkg::byteT   wrData,
    input  pep9Pkg::statusT statusNext,
    output pep9Pkg::byteT   regA,
    output pep9Pkg::byteT   regX,
    output pep9Pkg::statusT status
);

    always_ff @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
        begin
            regA   <= '0;
            regX   <= '0;
            status <= '0;
        end
        else
        begin
            status <= statusNext;   // Holds its value outside completions
            if (wrEn)
            begin
                if (wrSel == pep9Pkg::regSelX)
                    regX <= wrData;
                else
                    regA <= wrData;
            end
        end
    end

endmodule

//--- src/resultMerge.sv
// Unit result merge and write-back
module resultMerge
(
    input  logic            Sysclk,
    input  logic            arstN,
    execIf.sink             exec,
    unitResultIf.sink       addRes,
    unitResultIf.sink       shiftRes,
    input  pep9Pkg::statusT status,
    output logic            wrEn,
    output pep9Pkg::regSelT wrSel,
    output pep9Pkg::byteT   wrData,
    output pep9Pkg::statusT statusNext,
    output logic            resultValid,
    output logic            illegalOp
);

    logic               anyValid;
    logic               noneSeen;   // Illegal pulse waiting out the unit stage
    logic               selCarry;
    logic               selOverflow;
    logic               selWrite;
    pep9Pkg::statusT    selMask;
    pep9Pkg::statusT    flags;

    // Only one unit is valid at a time
    assign anyValid    = addRes.valid || shiftRes.valid;
    assign wrData      = addRes.valid ? addRes.value    : shiftRes.value;
    assign wrSel       = addRes.valid ? addRes.dest     : shiftRes.dest;
    assign selWrite    = addRes.valid ? addRes.writeEn  : shiftRes.writeEn;
    assign selCarry    = addRes.valid ? addRes.carry    : shiftRes.carry;
    assign selOverflow = addRes.valid ? addRes.overflow : shiftRes.overflow;
    assign selMask     = addRes.valid ? addRes.flagMask : shiftRes.flagMask;

    assign flags = '{n: wrData[7], z: wrData == '0, v: selOverflow, c: selCarry};

    assign wrEn       = anyValid && selWrite;
    assign statusNext = anyValid ? pep9Pkg::statusT'((flags & selMask) | (status & ~selMask))
                                 : status;

    always_ff @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
        begin
            noneSeen    <= 1'b0;
            resultValid <= 1'b0;
            illegalOp   <= 1'b0;
        end
        else
        begin
            noneSeen    <= exec.valid && exec.unitSel == pep9Pkg::unitNone;
            resultValid <= anyValid || noneSeen;
            illegalOp   <= noneSeen;
        end
    end

endmodule

//--- src/shiftUnit.sv
// Unary invert, negate, shift and rotate unit
module shiftUnit
(
    input  logic        Sysclk,
    input  logic        arstN,
    execIf.sink         exec,
    unitResultIf.source res
);

    logic               hit;
    pep9Pkg::byteT      a;
    pep9Pkg::byteT      nextValue;
    logic               nextCarry;
    logic               nextOverflow;
    pep9Pkg::statusT    nextMask;

    assign hit = exec.valid && exec.unitSel == pep9Pkg::unitShift;
    assign a   = exec.opndA;

    always_comb
    begin
        nextValue    = a;
        nextCarry    = 1'b0;
        nextOverflow = 1'b0;
        nextMask     = '{n: 1'b0, z: 1'b0, v: 1'b0, c: 1'b0};
        case (exec.aluOp)
            pep9Pkg::opNot:
            begin
                nextValue = ~a;
                nextMask  = '{n: 1'b1, z: 1'b1, v: 1'b0, c: 1'b0};
            end
            pep9Pkg::opNeg:
            begin
                nextValue    = 8'd0 - a;
                nextOverflow = a == 8'h80;      // -128 has no positive form
                nextMask     = '{n: 1'b1, z: 1'b1, v: 1'b1, c: 1'b0};
            end
            pep9Pkg::opAsl:
            begin
                nextValue    = {a[6:0], 1'b0};
                nextCarry    = a[7];
                nextOverflow = a[7] ^ a[6];     // Sign changed
                nextMask     = '{n: 1'b1, z: 1'b1, v: 1'b1, c: 1'b1};
            end
            pep9Pkg::opAsr:
            begin
                nextValue = {a[7], a[7:1]};
                nextCarry = a[0];
                nextMask  = '{n: 1'b1, z: 1'b1, v: 1'b0, c: 1'b1};
            end
            // Rotates go through the stored C bit
            pep9Pkg::opRol:
            begin
                nextValue = {a[6:0], exec.carryIn};
                nextCarry = a[7];
                nextMask  = '{n: 1'b0, z: 1'b0, v: 1'b0, c: 1'b1};
            end
            pep9Pkg::opRor:
            begin
                nextValue = {exec.carryIn, a[7:1]};
                nextCarry = a[0];
                nextMask  = '{n: 1'b0, z: 1'b0, v: 1'b0, c: 1'b1};
            end
            default: nextValue = a;
        endcase
    end

    always_ff @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
            res.valid <= 1'b0;
        else
            res.valid <= hit;
    end

    always_ff @(posedge Sysclk)
    begin
        if (hit)
        begin
            res.value    <= nextValue;
            res.carry    <= nextCarry;
            res.overflow <= nextOverflow;
            res.flagMask <= nextMask;
            res.dest     <= exec.dest;
            res.writeEn  <= exec.writeEn;
        end
    end

endmodule

//--- tests/pep9CoreChecker.sv
// Pep/9 core result checker
module pep9CoreChecker
(
    input  logic            Sysclk,
    input  logic            arstN,
    input  logic            instrValid,
    input  logic            instrReady,
    input  pep9Pkg::byteT   instrSpec,
    input  pep9Pkg::byteT   operand,
    input  logic            resultValid,
    input  logic            illegalOp,
    input  pep9Pkg::byteT   regA,
    input  pep9Pkg::byteT   regX,
    input  pep9Pkg::statusT status,
    output int              errorCount,
    output int              compareCount,
    output int              pendingCount
);

    pep9Pkg::byteT   shadowA;
    pep9Pkg::byteT   shadowX;
    pep9Pkg::statusT shadowSt;
    logic            shadowIllegal;
    pep9Pkg::byteT   expA[$];        // Expected state after each accepted instruction
    pep9Pkg::byteT   expX[$];
    pep9Pkg::statusT expSt[$];
    logic            expIllegal[$];
    int              acceptCycle[$];
    pep9Pkg::byteT   wantA;
    pep9Pkg::byteT   wantX;
    pep9Pkg::statusT wantSt;
    logic            wantIllegal;
    int              wantCycle;
    int              cycle;
    logic            inReset = 1'b1;
    string           testName = "none";

    initial
    begin
        errorCount   = 0;
        compareCount = 0;
        pendingCount = 0;
    end

    task automatic setTest(input string name);
        testName = name;
    endtask

    task automatic compareValue(input string field, input logic [7:0] expected,
                                input logic [7:0] actual);
        compareCount++;
        if (expected != actual)
        begin
            errorCount++;
            $display("CHECK FAILED test %s: %s expected 'h%0h, actual 'h%0h",
                     testName, field, expected, actual);
        end
    endtask

    // Reference model of one instruction on the shadow state
    function automatic void pep9Model
    (
        input  pep9Pkg::byteT   spec,
        input  pep9Pkg::byteT   imm,
        inout  pep9Pkg::byteT   a,
        inout  pep9Pkg::byteT   x,
        inout  pep9Pkg::statusT st,
        output logic            illegal
    );
        logic           unary;
        logic           useX;
        logic           write;
        logic           setNz;
        pep9Pkg::byteT  src;
        pep9Pkg::byteT  r;
        logic [8:0]     wide;

        unary   = spec >= pep9Pkg::specUnaryFirst && spec <= pep9Pkg::specUnaryLast;
        useX    = unary ? spec[0] : spec[3];
        src     = useX ? x : a;
        illegal = 1'b0;
        write   = 1'b1;
        setNz   = 1'b1;
        r       = src;
        wide    = '0;
        if (unary)
        begin
            case (spec & 8'hFE)
                8'h18: r = ~src;
                8'h1A:
                begin
                    r    = 8'h00 - src;
                    st.v = src == 8'h80;
                end
                8'h1C:
                begin
                    r    = src << 1;
                    st.v = r[7] != src[7];
                    st.c = src[7];
                end
                8'h1E:
                begin
                    r    = {src[7], src[7:1]};
                    st.c = src[0];
                end
                8'h20:
                begin
                    r     = {src[6:0], st.c};   // Old C enters at the bottom
                    st.c  = src[7];
                    setNz = 1'b0;
                end
                default:
                begin
                    r     = {st.c, src[7:1]};
                    st.c  = src[0];
                    setNz = 1'b0;
                end
            endcase
        end
        else if (spec[2:0] != pep9Pkg::addrImmediate)
            illegal = 1'b1;
        else
        begin
            case (spec[7:4])
                pep9Pkg::specAdd:
                begin
                    wide = {1'b0, src} + {1'b0, imm};
                    r    = wide[7:0];
                    st.c = wide[8];
                    st.v = src[7] == imm[7] && r[7] != src[7];
                end
                pep9Pkg::specSub, pep9Pkg::specCp:
                begin
                    r     = src - imm;
                    st.c  = src >= imm;   // Set when no borrow
                    st.v  = src[7] != imm[7] && r[7] != src[7];
                    write = spec[7:4] != pep9Pkg::specCp;
                end
                pep9Pkg::specAnd: r = src & imm;
                pep9Pkg::specOr:  r = src | imm;
                pep9Pkg::specLd:  r = imm;
                default:          illegal = 1'b1;
            endcase
        end
        if (!illegal && setNz)
        begin
            st.n = r[7];
            st.z = r == 8'h00;
        end
        if (!illegal && write)
        begin
            if (useX)
                x = r;
            else
                a = r;
        end
    endfunction

    always @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
        begin
            shadowA  = '0;
            shadowX  = '0;
            shadowSt = '0;
            cycle    = 0;
            inReset  = 1'b1;
            expA.delete();
            expX.delete();
            expSt.delete();
            expIllegal.delete();
            acceptCycle.delete();
        end
        else
        begin
            cycle++;
            if (inReset)
            begin
                compareValue("instrReady", 8'd1, {7'd0, instrReady});
                compareValue("resultValid", 8'd0, {7'd0, resultValid});
                compareValue("regA", 8'h00, regA);
                compareValue("regX", 8'h00, regX);
                compareValue("status", 8'h00, {4'h0, status});
                inReset = 1'b0;
            end
            if (instrValid && instrReady)
            begin
                pep9Model(instrSpec, operand, shadowA, shadowX, shadowSt, shadowIllegal);
                expA.push_back(shadowA);
                expX.push_back(shadowX);
                expSt.push_back(shadowSt);
                expIllegal.push_back(shadowIllegal);
                acceptCycle.push_back(cycle);
            end
            if (resultValid)
            begin
                if (expA.size() == 0)
                begin
                    errorCount++;
                    $display("Test %s: resultValid came with no instruction in flight",
                             testName);
                end
                else
                begin
                    wantA       = expA.pop_front();
                    wantX       = expX.pop_front();
                    wantSt      = expSt.pop_front();
                    wantIllegal = expIllegal.pop_front();
                    wantCycle   = acceptCycle.pop_front();
                    compareValue("regA", wantA, regA);
                    compareValue("regX", wantX, regX);
                    compareValue("status", {4'h0, wantSt}, {4'h0, status});
                    compareValue("illegalOp", {7'd0, wantIllegal}, {7'd0, illegalOp});
                    compareValue("latency", 8'(pep9Pkg::coreLatency), 8'(cycle - wantCycle));
                end
            end
        end
        pendingCount = expA.size();
    end

endmodule

//--- tests/pep9CoreTb.sv
// Pep/9 core testbench
module pep9CoreTb;

    localparam int resetCycles = 10;
    localparam int numRandom   = 200;
    localparam int maxDirected = 64;   // Upper bound on directed instructions
    localparam int maxGap      = 3;
    localparam int cycleLimit  = resetCycles + 200
                               + (maxDirected + numRandom) * (pep9Pkg::coreLatency + maxGap);

    // Random picks from the kept instruction set
    localparam pep9Pkg::byteT legalSpecs [24] = '{
        8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E, 8'h1F,
        8'h20, 8'h21, 8'h22, 8'h23, 8'h60, 8'h68, 8'h70, 8'h78,
        8'h80, 8'h88, 8'h90, 8'h98, 8'hA0, 8'hA8, 8'hC0, 8'hC8
    };

    logic            Sysclk;
    logic            arstN;
    logic            instrValid;
    pep9Pkg::byteT   instrSpec;
    pep9Pkg::byteT   operand;
    logic            instrReady;
    logic            resultValid;
    logic            illegalOp;
    pep9Pkg::byteT   regA;
    pep9Pkg::byteT   regX;
    pep9Pkg::statusT status;
    int              errorCount;
    int              compareCount;
    int              pendingCount;
    int              cycleCount = 0;
    int              seed;
    int              testCount = 0;
    int              testFails = 0;
    int              testErrStart;
    string           curTest;
    pep9Pkg::byteT   spec;
    logic [4:0]      pick;
    int              gap;

    pep9Core pep9Core_inst
    (
        .Sysclk      (Sysclk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instrSpec   (instrSpec),
        .operand     (operand),
        .instrReady  (instrReady),
        .resultValid (resultValid),
        .illegalOp   (illegalOp),
        .regA        (regA),
        .regX        (regX),
        .status      (status)
    );

    pep9CoreChecker checkerInst
    (
        .Sysclk       (Sysclk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instrReady   (instrReady),
        .instrSpec    (instrSpec),
        .operand      (operand),
        .resultValid  (resultValid),
        .illegalOp    (illegalOp),
        .regA         (regA),
        .regX         (regX),
        .status       (status),
        .errorCount   (errorCount),
        .compareCount (compareCount),
        .pendingCount (pendingCount)
    );

    initial
    begin
        Sysclk = 1'b0;
        forever #4 Sysclk = ~Sysclk;
    end

    always @(posedge Sysclk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout after %0d cycles, instructions stopped completing", cycleCount);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Holds the request until the DUT is ready, then idles for gap cycles
    task automatic sendInstr(input pep9Pkg::byteT specIn, input pep9Pkg::byteT imm,
                             input int gapIn);
        @(negedge Sysclk);
        instrValid = 1'b1;
        instrSpec  = specIn;
        operand    = imm;
        while (!instrReady)
            @(negedge Sysclk);
        @(posedge Sysclk);               // Accepted on this edge
        if (gapIn > 0)
        begin
            @(negedge Sysclk);
            instrValid = 1'b0;
            repeat (gapIn - 1) @(negedge Sysclk);
        end
    endtask

    task automatic startTest(input string name);
        curTest      = name;
        testErrStart = errorCount;
        checkerInst.setTest(name);
    endtask

    task automatic finishTest();
        @(negedge Sysclk);
        instrValid = 1'b0;
        while (pendingCount != 0)
            @(negedge Sysclk);
        testCount++;
        if (errorCount != testErrStart)
        begin
            testFails++;
            $display("Test %s: failed, %0d errors", curTest, errorCount - testErrStart);
        end
        else
            $display("Test %s: ok", curTest);
    endtask

    initial
    begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instrSpec  = '0;
        operand    = '0;
        seed       = 32'h10b174ad;

        startTest("reset");
        repeat (resetCycles) @(posedge Sysclk);
        @(negedge Sysclk);
        arstN = 1'b1;
        finishTest();

        startTest("loadAddSub");
        sendInstr(8'hC0, 8'h7F, 0);      // LDWA
        sendInstr(8'h60, 8'h01, 1);      // Signed overflow to 0x80
        sendInstr(8'hC8, 8'hFF, 0);
        sendInstr(8'h68, 8'h01, 0);      // Carry out and zero
        sendInstr(8'h70, 8'h01, 2);
        sendInstr(8'h78, 8'h05, 0);      // Borrow
        sendInstr(8'hA0, 8'h7F, 0);      // CPWA
        sendInstr(8'hA8, 8'hFB, 1);      // CPWX equal
        finishTest();

        startTest("andOr");
        sendInstr(8'hC0, 8'h80, 0);
        sendInstr(8'h70, 8'h01, 0);      // Sets V and C
        sendInstr(8'h80, 8'h0F, 1);
        sendInstr(8'h90, 8'h80, 0);
        sendInstr(8'hC8, 8'h3C, 0);
        sendInstr(8'h88, 8'hC3, 2);      // Zero result
        sendInstr(8'h98, 8'h81, 0);
        finishTest();

        startTest("unary");
        sendInstr(8'hC0, 8'h80, 0);
        sendInstr(8'h1A, 8'h00, 0);      // NEGA of 0x80
        sendInstr(8'hC8, 8'h41, 1);
        sendInstr(8'h18, 8'h00, 0);
        sendInstr(8'h19, 8'h00, 0);
        sendInstr(8'h1B, 8'h00, 2);
        sendInstr(8'h1C, 8'h00, 0);
        sendInstr(8'h1D, 8'h00, 0);
        sendInstr(8'h1E, 8'h00, 1);
        sendInstr(8'h1F, 8'h00, 0);
        sendInstr(8'hC0, 8'h81, 0);
        sendInstr(8'h60, 8'h80, 0);      // C set before the rotates
        sendInstr(8'h20, 8'h00, 0);
        sendInstr(8'h21, 8'h00, 1);
        sendInstr(8'h22, 8'h00, 0);
        sendInstr(8'h23, 8'h00, 0);
        sendInstr(8'h22, 8'h00, 0);
        finishTest();

        startTest("illegal");
        sendInstr(8'h00, 8'h12, 0);
        sendInstr(8'h17, 8'h34, 0);
        sendInstr(8'h24, 8'h56, 1);
        sendInstr(8'h2F, 8'h78, 0);
        sendInstr(8'h61, 8'h01, 0);      // ADDA in a non-immediate mode
        sendInstr(8'hC9, 8'h99, 0);
        sendInstr(8'h75, 8'h05, 2);
        sendInstr(8'h10, 8'h00, 0);
        sendInstr(8'h50, 8'hAA, 0);
        sendInstr(8'hB0, 8'h55, 1);
        sendInstr(8'hD8, 8'h0F, 0);
        sendInstr(8'hF0, 8'hF0, 0);
        finishTest();

        startTest("random");
        for (int i = 0; i < numRandom; i++)
        begin
            if (($random(seed) & 1) != 0)
            begin
                pick = 5'($unsigned($random(seed)) % 24);
                spec = legalSpecs[pick];
            end
            else
                spec = pep9Pkg::byteT'($random(seed));
            gap = $random(seed) & maxGap;
            sendInstr(spec, pep9Pkg::byteT'($random(seed)), gap);
        end
        finishTest();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, testFails, compareCount, errorCount,
                 pep9Core_inst.assertInst.failCount);
        if (errorCount == 0 && testFails == 0 && pep9Core_inst.assertInst.failCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tests/pep9Core_assert.sv
// Pep/9 core handshake assertions
module pep9CoreAssert
(
    input logic Sysclk,
    input logic arstN,
    input logic instrValid,
    input logic instrReady,
    input logic resultValid
);

    logic accept;
    logic inFlight;
    int   failCount = 0;    // Assertion failures so far

    assign accept = instrValid && instrReady;

    always_ff @(posedge Sysclk or negedge arstN)
    begin
        if (!arstN)
            inFlight <= 1'b0;
        else if (accept)
            inFlight <= 1'b1;   // A new acceptance can share the completion cycle
        else if (resultValid)
            inFlight <= 1'b0;
    end

    resultPulse: assert property (@(posedge Sysclk) disable iff (!arstN)
        resultValid |=> !resultValid)
        else
        begin
            failCount++;
            $error("resultValid lasted more than one cycle");
        end

    latencyAfterAccept: assert property (@(posedge Sysclk) disable iff (!arstN)
        $past(accept, pep9Pkg::coreLatency) |-> resultValid)
        else
        begin
            failCount++;
            $error("no completion at the expected edge after acceptance");
        end

    latencyOfResult: assert property (@(posedge Sysclk) disable iff (!arstN)
        resultValid |-> $past(accept, pep9Pkg::coreLatency))
        else
        begin
            failCount++;
            $error("completion without a matching acceptance");
        end

    busyNotReady: assert property (@(posedge Sysclk) disable iff (!arstN)
        inFlight && !resultValid |-> !instrReady)
        else
        begin
            failCount++;
            $error("instrReady high while an instruction is in flight");
        end

endmodule

bind pep9Core pep9CoreAssert assertInst
(
    .Sysclk      (Sysclk),
    .arstN       (arstN),
    .instrValid  (instrValid),
    .instrReady  (instrReady),
    .resultValid (resultValid)
);
